//--- design/aipPkg.sv
`default_nettype none

package aipPkg;

  localparam int DATA_WIDTH         = 32;
  localparam int MEM_ADDR_MAX_WIDTH = 16;
  localparam int CONF_REG_COUNT     = 4;

  localparam logic [DATA_WIDTH-1:0] IP_ID = 32'h0000200F;

  // Host target selection
  typedef enum logic [4:0] {
    CFG_MEMIN_DATA   = 5'd0,
    CFG_MEMIN_ADDR   = 5'd1,
    CFG_MEMOUT_DATA  = 5'd2,
    CFG_MEMOUT_ADDR  = 5'd3,
    CFG_CONFREG_DATA = 5'd4,
    CFG_CONFREG_ADDR = 5'd5,
    CFG_STATUS       = 5'd30,
    CFG_ID           = 5'd31
  } aipConfig_e;

  typedef struct packed {
    aipConfig_e            cfg;
    logic                  read;
    logic                  write;
    logic [DATA_WIDTH-1:0] data;
  } hostBus_t;

  // Busy sits in bit 0
  typedef struct packed {
    logic trap;
    logic writeMem;
    logic readMem;
    logic busy;
  } coreStatus_t;

  typedef struct packed {
    logic                          en;
    logic [MEM_ADDR_MAX_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0]         data;
  } memWrite_t;

endpackage

`default_nettype wire

//--- design/aipDualPortRam.sv
`default_nettype none

module aipDualPortRam #(
  parameter int ADDR_WIDTH = 8
) (
  input  wire                                    clk,
  input  aipPkg::memWrite_t                      wr_i,
  input  wire  [aipPkg::MEM_ADDR_MAX_WIDTH-1:0]  rdAddr_i,
  output logic [aipPkg::DATA_WIDTH-1:0]          rdData_o
);

  logic [aipPkg::DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

  always_ff @(posedge clk) begin
    if (wr_i.en) begin
      mem[wr_i.addr[ADDR_WIDTH-1:0]] <= wr_i.data;
    end
  end

  // Async read port
  assign rdData_o = mem[rdAddr_i[ADDR_WIDTH-1:0]];

endmodule

`default_nettype wire

//--- design/aipConfRegFile.sv
`default_nettype none

module aipConfRegFile (
  input  wire                                                   clk,
  input  wire                                                   rst,
  input  wire                                                   wrEn_i,
  input  wire  [$clog2(aipPkg::CONF_REG_COUNT)-1:0]             wrAddr_i,
  input  wire  [aipPkg::DATA_WIDTH-1:0]                         wrData_i,
  output logic [aipPkg::CONF_REG_COUNT*aipPkg::DATA_WIDTH-1:0]  regs_o
);

  logic [aipPkg::DATA_WIDTH-1:0] confRegs [aipPkg::CONF_REG_COUNT];

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int k = 0; k < aipPkg::CONF_REG_COUNT; k++) begin
        confRegs[k] <= '0;
      end
    end else if (wrEn_i) begin
      confRegs[wrAddr_i] <= wrData_i;
    end
  end

  // Whole file seen by the core at once
  always_comb begin
    for (int k = 0; k < aipPkg::CONF_REG_COUNT; k++) begin
      regs_o[k*aipPkg::DATA_WIDTH +: aipPkg::DATA_WIDTH] = confRegs[k];
    end
  end

endmodule

`default_nettype wire

//--- design/aipStatusReg.sv
`default_nettype none

module aipStatusReg (
  input  wire                            clk,
  input  wire                            rst,
  input  wire                            wrEn_i,
  input  wire  [aipPkg::DATA_WIDTH-1:0]  wrData_i,
  input  aipPkg::coreStatus_t            coreStatus_i,
  input  wire                            doneCore_i,
  output logic [aipPkg::DATA_WIDTH-1:0]  statusWord_o,
  output logic                           intAIP_o
);

  logic intMask;
  logic pending;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      intMask <= 1'b0;
    end else if (wrEn_i) begin
      intMask <= wrData_i[8];
    end
  end

  // Done pulse has priority over a host clear
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pending <= 1'b0;
    end else if (doneCore_i) begin
      pending <= 1'b1;
    end else if (wrEn_i && wrData_i[16]) begin
      pending <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      intAIP_o <= 1'b0;
    end else begin
      intAIP_o <= pending & intMask; // One cycle behind the flags
    end
  end

  assign statusWord_o = {15'd0, pending, 7'd0, intMask, 4'd0, coreStatus_i};

endmodule

`default_nettype wire

//--- design/aipCtrl.sv
`default_nettype none

module aipCtrl #(
  parameter int MEM_IN_ADDR_WIDTH  = 14,
  parameter int MEM_OUT_ADDR_WIDTH = 9
) (
  input  wire                                         clk,
  input  wire                                         rst,
  input  wire                                         en_i,
  input  aipPkg::hostBus_t                            hostBus_i,
  output aipPkg::memWrite_t                           memInWr_o,
  output logic [aipPkg::MEM_ADDR_MAX_WIDTH-1:0]       memOutRdAddr_o,
  input  wire  [aipPkg::DATA_WIDTH-1:0]               memOutRdData_i,
  output logic                                        confRegWrEn_o,
  output logic [$clog2(aipPkg::CONF_REG_COUNT)-1:0]   confRegAddr_o,
  output logic                                        statusWrEn_o,
  input  wire  [aipPkg::DATA_WIDTH-1:0]               statusWord_i,
  output logic [aipPkg::DATA_WIDTH-1:0]               dataAIP_o
);

  localparam int ADDR_W = aipPkg::MEM_ADDR_MAX_WIDTH;
  localparam int CONF_W = $clog2(aipPkg::CONF_REG_COUNT);

  logic [MEM_IN_ADDR_WIDTH-1:0]  memInPtr;
  logic [MEM_OUT_ADDR_WIDTH-1:0] memOutPtr;
  logic [CONF_W-1:0]             confRegPtr;

  logic memInWrEn;
  logic memInAddrLd;
  logic memOutAddrLd;
  logic memOutRdStb;
  logic confAddrLd;

  // Strobe decode
  assign memInWrEn    = hostBus_i.write && hostBus_i.cfg == aipPkg::CFG_MEMIN_DATA;
  assign memInAddrLd  = hostBus_i.write && hostBus_i.cfg == aipPkg::CFG_MEMIN_ADDR;
  assign memOutAddrLd = hostBus_i.write && hostBus_i.cfg == aipPkg::CFG_MEMOUT_ADDR;
  assign memOutRdStb  = hostBus_i.read && hostBus_i.cfg == aipPkg::CFG_MEMOUT_DATA;
  assign confAddrLd   = hostBus_i.write && hostBus_i.cfg == aipPkg::CFG_CONFREG_ADDR;

  assign confRegWrEn_o = hostBus_i.write && hostBus_i.cfg == aipPkg::CFG_CONFREG_DATA;
  assign statusWrEn_o  = hostBus_i.write && hostBus_i.cfg == aipPkg::CFG_STATUS;

  // Enable freezes pointers, data writes still go through
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      memInPtr   <= '0;
      memOutPtr  <= '0;
      confRegPtr <= '0;
    end else if (en_i) begin
      if (memInAddrLd) begin
        memInPtr <= hostBus_i.data[MEM_IN_ADDR_WIDTH-1:0];
      end else if (memInWrEn) begin
        memInPtr <= memInPtr + 1'b1;
      end

      if (memOutAddrLd) begin
        memOutPtr <= hostBus_i.data[MEM_OUT_ADDR_WIDTH-1:0];
      end else if (memOutRdStb) begin
        memOutPtr <= memOutPtr + 1'b1;
      end

      if (confAddrLd) begin
        confRegPtr <= hostBus_i.data[CONF_W-1:0];
      end else if (confRegWrEn_o) begin
        confRegPtr <= confRegPtr + 1'b1; // Wraps 3 -> 0
      end
    end
  end

  always_comb begin
    memInWr_o.en   = memInWrEn;
    memInWr_o.addr = ADDR_W'(memInPtr);
    memInWr_o.data = hostBus_i.data;
  end

  assign memOutRdAddr_o = ADDR_W'(memOutPtr);
  assign confRegAddr_o  = confRegPtr;

  // Readback mux
  always_comb begin
    case (hostBus_i.cfg)
      aipPkg::CFG_MEMOUT_DATA: dataAIP_o = memOutRdData_i;
      aipPkg::CFG_STATUS:      dataAIP_o = statusWord_i;
      default:                 dataAIP_o = aipPkg::IP_ID;
    endcase
  end

endmodule

`default_nettype wire

//--- design/aipTop.sv
`default_nettype none

module aipTop #(
  parameter int MEM_IN_ADDR_WIDTH  = 14,
  parameter int MEM_OUT_ADDR_WIDTH = 9
) (
  input  wire                                                   clk,
  input  wire                                                   rst,
  input  wire                                                   en_i,
  input  aipPkg::hostBus_t                                      hostBus_i,
  input  wire                                                   startAIP_i,
  output logic [aipPkg::DATA_WIDTH-1:0]                         dataAIP_o,
  output logic                                                  intAIP_o,
  input  wire  [aipPkg::MEM_ADDR_MAX_WIDTH-1:0]                 rdAddrMemIn_i,
  output logic [aipPkg::DATA_WIDTH-1:0]                         rdDataMemIn_o,
  input  aipPkg::memWrite_t                                     memOutWr_i,
  output logic [aipPkg::CONF_REG_COUNT*aipPkg::DATA_WIDTH-1:0]  confRegs_o,
  input  aipPkg::coreStatus_t                                   coreStatus_i,
  input  wire                                                   doneCore_i,
  output logic                                                  startCore_o
);

  aipPkg::memWrite_t                         memInWr;
  logic [aipPkg::MEM_ADDR_MAX_WIDTH-1:0]     memOutRdAddr;
  logic [aipPkg::DATA_WIDTH-1:0]             memOutRdData;
  logic                                      confRegWrEn;
  logic [$clog2(aipPkg::CONF_REG_COUNT)-1:0] confRegAddr;
  logic                                      statusWrEn;
  logic [aipPkg::DATA_WIDTH-1:0]             statusWord;

  assign startCore_o = startAIP_i;

  aipCtrl #(
    .MEM_IN_ADDR_WIDTH  (MEM_IN_ADDR_WIDTH),
    .MEM_OUT_ADDR_WIDTH (MEM_OUT_ADDR_WIDTH)
  ) uCtrl (
    .clk            (clk),
    .rst            (rst),
    .en_i           (en_i),
    .hostBus_i      (hostBus_i),
    .memInWr_o      (memInWr),
    .memOutRdAddr_o (memOutRdAddr),
    .memOutRdData_i (memOutRdData),
    .confRegWrEn_o  (confRegWrEn),
    .confRegAddr_o  (confRegAddr),
    .statusWrEn_o   (statusWrEn),
    .statusWord_i   (statusWord),
    .dataAIP_o      (dataAIP_o)
  );

  // Host fills, core reads
  aipDualPortRam #(.ADDR_WIDTH(MEM_IN_ADDR_WIDTH)) uMemIn (
    .clk      (clk),
    .wr_i     (memInWr),
    .rdAddr_i (rdAddrMemIn_i),
    .rdData_o (rdDataMemIn_o)
  );

  // Core fills, host reads
  aipDualPortRam #(.ADDR_WIDTH(MEM_OUT_ADDR_WIDTH)) uMemOut (
    .clk      (clk),
    .wr_i     (memOutWr_i),
    .rdAddr_i (memOutRdAddr),
    .rdData_o (memOutRdData)
  );

  aipConfRegFile uConfRegs (
    .clk      (clk),
    .rst      (rst),
    .wrEn_i   (confRegWrEn),
    .wrAddr_i (confRegAddr),
    .wrData_i (hostBus_i.data),
    .regs_o   (confRegs_o)
  );

  aipStatusReg uStatus (
    .clk          (clk),
    .rst          (rst),
    .wrEn_i       (statusWrEn),
    .wrData_i     (hostBus_i.data),
    .coreStatus_i (coreStatus_i),
    .doneCore_i   (doneCore_i),
    .statusWord_o (statusWord),
    .intAIP_o     (intAIP_o)
  );

endmodule

`default_nettype wire

//--- bench/aipCtrl_asserts.sv
`default_nettype none

module aipCtrlAsserts (
  input  wire                                         clk,
  input  wire                                         rst,
  input  wire                                         en_i,
  input  aipPkg::memWrite_t                           memInWr_i,
  input  wire  [aipPkg::MEM_ADDR_MAX_WIDTH-1:0]       memOutRdAddr_i,
  input  wire                                         confRegWrEn_i,
  input  wire  [$clog2(aipPkg::CONF_REG_COUNT)-1:0]   confRegAddr_i,
  input  wire                                         statusWrEn_i
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CONF_W = $clog2(aipPkg::CONF_REG_COUNT);

  // Pointer steps on each enabled data write and wraps from 3 to 0
  confPtrWrap: assert property (@(posedge clk) disable iff (!rst)
    (en_i && confRegWrEn_i) |=> confRegAddr_i == CONF_W'($past(confRegAddr_i) + 1'b1))
    else $error("configuration register pointer did not step or wrap after a write");

  // Only one host target can take a write
  oneWriteTarget: assert property (@(posedge clk) disable iff (!rst)
    $onehot0({memInWr_i.en, confRegWrEn_i, statusWrEn_i}))
    else $error("more than one write target selected in one cycle");

  ptrsClearAfterReset: assert property (@(posedge clk)
    $rose(rst) |-> (memInWr_i.addr == '0 && memOutRdAddr_i == '0 && confRegAddr_i == '0))
    else $error("pointers not zero after reset release");

endmodule

bind aipCtrl aipCtrlAsserts uCtrlAsserts (
  .clk            (clk),
  .rst            (rst),
  .en_i           (en_i),
  .memInWr_i      (memInWr_o),
  .memOutRdAddr_i (memOutRdAddr_o),
  .confRegWrEn_i  (confRegWrEn_o),
  .confRegAddr_i  (confRegAddr_o),
  .statusWrEn_i   (statusWrEn_o)
);

`default_nettype wire

//--- bench/aipTb.sv
`default_nettype none

module aipTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int IN_W       = 6;
  localparam int OUT_W      = 5;
  localparam int NUM_CYCLES = 2000;
  localparam int MAX_CYCLES = 2 * NUM_CYCLES; // Timeout limit

  logic                                               clk;
  logic                                               rst;
  logic                                               en;
  aipPkg::hostBus_t                                   hostBus;
  logic                                               startAIP;
  logic [aipPkg::DATA_WIDTH-1:0]                      dataAIP;
  logic                                               intAIP;
  logic [aipPkg::MEM_ADDR_MAX_WIDTH-1:0]              rdAddrMemIn;
  logic [aipPkg::DATA_WIDTH-1:0]                      rdDataMemIn;
  aipPkg::memWrite_t                                  memOutWr;
  logic [aipPkg::CONF_REG_COUNT*aipPkg::DATA_WIDTH-1:0] confRegs;
  aipPkg::coreStatus_t                                coreStatus;
  logic                                               doneCore;
  logic                                               startCore;

  // Reference model state
  logic [aipPkg::DATA_WIDTH-1:0] memInModel [2**IN_W];
  bit                            memInValid [2**IN_W];
  logic [aipPkg::DATA_WIDTH-1:0] memOutModel [2**OUT_W];
  bit                            memOutValid [2**OUT_W];
  logic [aipPkg::DATA_WIDTH-1:0] confModel [aipPkg::CONF_REG_COUNT];
  logic [IN_W-1:0]               inPtr;
  logic [OUT_W-1:0]              outPtr;
  logic [1:0]                    confPtr;
  logic                          mask;
  logic                          pend;
  logic                          expInt;
  logic [IN_W-1:0]               lastInAddr;

  integer seed;
  int     cycleCnt = 0;
  int     failCount;

  aipTop #(
    .MEM_IN_ADDR_WIDTH  (IN_W),
    .MEM_OUT_ADDR_WIDTH (OUT_W)
  ) u_aipTop (
    .clk           (clk),
    .rst           (rst),
    .en_i          (en),
    .hostBus_i     (hostBus),
    .startAIP_i    (startAIP),
    .dataAIP_o     (dataAIP),
    .intAIP_o      (intAIP),
    .rdAddrMemIn_i (rdAddrMemIn),
    .rdDataMemIn_o (rdDataMemIn),
    .memOutWr_i    (memOutWr),
    .confRegs_o    (confRegs),
    .coreStatus_i  (coreStatus),
    .doneCore_i    (doneCore),
    .startCore_o   (startCore)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycleCnt <= cycleCnt + 1;
    if (cycleCnt >= MAX_CYCLES) begin
      $display("Run did not finish within %0d cycles", MAX_CYCLES);
      $display("Checks failed");
      $fatal(1, "timeout");
    end
  end

  task automatic reportFailure(input string msg);
    failCount++;
    $display("mismatch at %0t ns: %s", $time, msg);
    $display("Checks failed");
    $fatal(1, "first check failure, run stopped");
  endtask

  // Weighted toward data ports, code 12 is unused and reads as ID
  function automatic aipPkg::aipConfig_e pickConfig(input logic [3:0] r);
    case (r)
      4'd0, 4'd1, 4'd2: pickConfig = aipPkg::CFG_MEMIN_DATA;
      4'd3:             pickConfig = aipPkg::CFG_MEMIN_ADDR;
      4'd4, 4'd5:       pickConfig = aipPkg::CFG_MEMOUT_DATA;
      4'd6:             pickConfig = aipPkg::CFG_MEMOUT_ADDR;
      4'd7, 4'd8:       pickConfig = aipPkg::CFG_CONFREG_DATA;
      4'd9:             pickConfig = aipPkg::CFG_CONFREG_ADDR;
      4'd10, 4'd11:     pickConfig = aipPkg::CFG_STATUS;
      4'd12:            pickConfig = aipPkg::CFG_ID;
      4'd13:            pickConfig = aipPkg::aipConfig_e'(5'd12);
      default:          pickConfig = aipPkg::CFG_CONFREG_DATA;
    endcase
  endfunction

  task automatic driveCycle(input int idx);
    logic [31:0]                           rnd;
    logic [31:0]                           rnd2;
    aipPkg::hostBus_t                      bus;
    aipPkg::memWrite_t                     wr;
    logic [aipPkg::MEM_ADDR_MAX_WIDTH-1:0] rdAddr;
    logic                                  enNext;
    rnd       = $random(seed);
    rnd2      = $random(seed);
    bus.cfg   = pickConfig(rnd[3:0]);
    bus.write = rnd[4];
    bus.read  = rnd[5];
    bus.data  = $random(seed);
    enNext    = (idx % 250 >= 200) ? 1'b0 : (rnd[8:6] != 3'd0); // Long low-enable stretches
    if (idx < 2) begin
      bus.cfg   = (idx == 0) ? aipPkg::CFG_ID : aipPkg::CFG_STATUS;
      bus.write = 1'b0;
      bus.read  = 1'b0;
    end
    wr.en   = (idx >= 2) && rnd[17];
    wr.addr = rnd2[15:0];
    wr.data = $random(seed);
    rdAddr  = rnd2[31:16];
    if (rnd[18]) begin
      rdAddr[IN_W-1:0] = lastInAddr; // Revisit the last host write
    end
    @(posedge clk);
    hostBus     <= bus;
    en          <= enNext;
    startAIP    <= rnd[9];
    doneCore    <= (idx >= 2) && (rnd[12:10] == 3'd0);
    coreStatus  <= (idx >= 2) ? rnd[16:13] : 4'd0;
    memOutWr    <= wr;
    rdAddrMemIn <= rdAddr;
  endtask

  task automatic checkOutputs();
    logic [31:0]  expStatus;
    logic [31:0]  expData;
    logic [127:0] expConf;
    logic         checkData;
    expStatus = 32'(coreStatus) | (32'(mask) << 8) | (32'(pend) << 16);
    expConf   = {confModel[3], confModel[2], confModel[1], confModel[0]};
    checkData = 1'b1;
    case (hostBus.cfg)
      aipPkg::CFG_MEMOUT_DATA: begin
        expData   = memOutModel[outPtr];
        checkData = memOutValid[outPtr]; // Unwritten words hold X
      end
      aipPkg::CFG_STATUS: expData = expStatus;
      default:            expData = aipPkg::IP_ID;
    endcase
    assert (startCore === startAIP)
      else reportFailure("startCore_o does not follow startAIP_i");
    assert (intAIP === expInt)
      else reportFailure($sformatf("intAIP_o got %b expected %b", intAIP, expInt));
    assert (confRegs === expConf)
      else reportFailure($sformatf("confRegs_o got %h expected %h", confRegs, expConf));
    assert (u_aipTop.statusWord === expStatus)
      else reportFailure($sformatf("status word got %h expected %h",
                                   u_aipTop.statusWord, expStatus));
    if (checkData) begin
      assert (dataAIP === expData)
        else reportFailure($sformatf("dataAIP_o cfg %0d got %h expected %h",
                                     hostBus.cfg, dataAIP, expData));
    end
    if (memInValid[rdAddrMemIn[IN_W-1:0]]) begin
      assert (rdDataMemIn === memInModel[rdAddrMemIn[IN_W-1:0]])
        else reportFailure($sformatf("rdDataMemIn_o at %h got %h", rdAddrMemIn, rdDataMemIn));
    end
  endtask

  // Applies the inputs now on the pins as the next rising edge will
  task automatic updateModel();
    logic               wr;
    aipPkg::aipConfig_e cfg;
    wr     = hostBus.write;
    cfg    = hostBus.cfg;
    expInt = pend & mask;
    if (wr && cfg == aipPkg::CFG_STATUS) begin
      mask = hostBus.data[8];
      if (hostBus.data[16]) begin
        pend = 1'b0;
      end
    end
    if (doneCore) begin
      pend = 1'b1; // Set wins over clear
    end
    if (memOutWr.en) begin
      memOutModel[memOutWr.addr[OUT_W-1:0]] = memOutWr.data;
      memOutValid[memOutWr.addr[OUT_W-1:0]] = 1'b1;
    end
    if (wr && cfg == aipPkg::CFG_MEMIN_DATA) begin
      memInModel[inPtr] = hostBus.data;
      memInValid[inPtr] = 1'b1;
      lastInAddr = inPtr;
      if (en) begin
        inPtr = inPtr + 1'b1;
      end
    end
    if (wr && cfg == aipPkg::CFG_CONFREG_DATA) begin
      confModel[confPtr] = hostBus.data;
      if (en) begin
        confPtr = confPtr + 1'b1;
      end
    end
    if (en && wr && cfg == aipPkg::CFG_MEMIN_ADDR) begin
      inPtr = hostBus.data[IN_W-1:0];
    end
    if (en && wr && cfg == aipPkg::CFG_MEMOUT_ADDR) begin
      outPtr = hostBus.data[OUT_W-1:0];
    end
    if (en && wr && cfg == aipPkg::CFG_CONFREG_ADDR) begin
      confPtr = hostBus.data[1:0];
    end
    if (en && hostBus.read && cfg == aipPkg::CFG_MEMOUT_DATA) begin
      outPtr = outPtr + 1'b1;
    end
  endtask

  initial begin
    seed        = 32'hc325_18ba;
    failCount   = 0;
    rst         = 1'b0;
    en          = 1'b0;
    hostBus     = '0;
    startAIP    = 1'b0;
    rdAddrMemIn = '0;
    memOutWr    = '0;
    coreStatus  = '0;
    doneCore    = 1'b0;
    inPtr       = '0;
    outPtr      = '0;
    confPtr     = '0;
    mask        = 1'b0;
    pend        = 1'b0;
    expInt      = 1'b0;
    lastInAddr  = '0;
    for (int k = 0; k < aipPkg::CONF_REG_COUNT; k++) begin
      confModel[k] = '0;
    end
    repeat (4) @(posedge clk);
    rst <= 1'b1;
    for (int i = 0; i < NUM_CYCLES; i++) begin
      driveCycle(i);
      @(negedge clk);
      checkOutputs();
      updateModel();
    end
    if (failCount == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("Checks failed");
      $fatal(1, "%0d checks did not match", failCount);
    end
  end

endmodule

`default_nettype wire

//--- sim.f
design/aipPkg.sv
design/aipDualPortRam.sv
design/aipConfRegFile.sv
design/aipStatusReg.sv
design/aipCtrl.sv
design/aipTop.sv
bench/aipCtrl_asserts.sv
bench/aipTb.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench, exit status reports pass or fail
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module aipTb -f sim.f -o aipSim &&
./obj_dir/aipSim || exit 1
